/* source/rv_macros.svh */
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

`define XLEN      32
`define REG_IDX_W 5

// Major opcodes
`define OP_LOAD     7'b0000011 // Decodes as no-operation
`define OP_STORE    7'b0100011 // Decodes as no-operation
`define OP_BRANCH   7'b1100011
`define OP_JALR     7'b1100111
`define OP_MISC_MEM 7'b0001111
`define OP_JAL      7'b1101111
`define OP_REG_IMM  7'b0010011
`define OP_REG_REG  7'b0110011
`define OP_ENVIRON  7'b1110011
`define OP_AUIPC    7'b0010111
`define OP_LUI      7'b0110111

// ALU funct3
`define F3_ADD_SUB 3'b000
`define F3_SLL     3'b001
`define F3_SLT     3'b010
`define F3_SLTU    3'b011
`define F3_XOR     3'b100
`define F3_SRL_SRA 3'b101
`define F3_OR      3'b110
`define F3_AND     3'b111

// Branch funct3
`define F3_BEQ  3'b000
`define F3_BNE  3'b001
`define F3_BLT  3'b100
`define F3_BGE  3'b101
`define F3_BLTU 3'b110
`define F3_BGEU 3'b111

`define F7_ALT 7'b0100000 // sub and sra

`define ALU_ADD  4'd0
`define ALU_SUB  4'd1
`define ALU_SLL  4'd2
`define ALU_SLT  4'd3
`define ALU_SLTU 4'd4
`define ALU_XOR  4'd5
`define ALU_SRL  4'd6
`define ALU_SRA  4'd7
`define ALU_OR   4'd8
`define ALU_AND  4'd9

`define CLS_NOP    3'd0
`define CLS_ALU    3'd1
`define CLS_LUI    3'd2
`define CLS_AUIPC  3'd3
`define CLS_BRANCH 3'd4
`define CLS_JAL    3'd5
`define CLS_JALR   3'd6
`define CLS_HALT   3'd7

`endif

/* source/rv_pkg.sv */
`default_nettype none

`include "rv_macros.svh"

package rv_pkg;

  // Register value, instruction, PC or immediate
  typedef logic [`XLEN-1:0] word_t;

  typedef logic [`REG_IDX_W-1:0] reg_idx_t;

  // Branch condition, taken straight from funct3
  typedef logic [2:0] funct3_t;

  typedef logic [3:0] alu_op_t;     // One of the ALU_* codes
  typedef logic [2:0] insn_class_t; // One of the CLS_* codes

endpackage

`default_nettype wire

/* source/rv_decode_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface rv_decode_if;
  import rv_pkg::*;

  insn_class_t insn_class;
  alu_op_t     alu_op;
  logic        use_imm;   // Immediate as second ALU operand
  word_t       imm;
  reg_idx_t    rs1;
  reg_idx_t    rs2;
  reg_idx_t    rd;
  logic        reg_write; // Already low for x0
  funct3_t     cmp_op;

  modport decode (
    output insn_class, alu_op, use_imm, imm, rs1, rs2, rd, reg_write, cmp_op
  );

  // Class gates the branch condition
  modport execute (
    input insn_class, alu_op, use_imm, imm, cmp_op
  );

  modport result (
    input insn_class, imm, rd, reg_write
  );

endinterface

`default_nettype wire

/* source/rv_decode.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rv_macros.svh"

module rv_decode (
  input  rv_pkg::word_t insn,
  rv_decode_if.decode   dec
);
  import rv_pkg::*;

  logic [6:0] opcode;
  funct3_t    funct3;
  logic [6:0] funct7;
  word_t      imm_i;
  word_t      imm_b;
  word_t      imm_j;
  word_t      imm_u;

  assign opcode = insn[6:0];
  assign funct3 = insn[14:12];
  assign funct7 = insn[31:25];

  assign dec.rd     = insn[11:7];
  assign dec.rs1    = insn[19:15];
  assign dec.rs2    = insn[24:20];
  assign dec.cmp_op = funct3;

  // Sign-extended immediate formats
  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
  assign imm_u = {insn[31:12], 12'b0}; // Already shifted

  always_comb begin
    dec.insn_class = `CLS_NOP;
    dec.imm        = imm_i;
    dec.use_imm    = 1'b0;
    case (opcode)
      `OP_LUI: begin
        dec.insn_class = `CLS_LUI;
        dec.imm        = imm_u;
      end
      `OP_AUIPC: begin
        dec.insn_class = `CLS_AUIPC;
        dec.imm        = imm_u;
      end
      `OP_JAL: begin
        dec.insn_class = `CLS_JAL;
        dec.imm        = imm_j;
      end
      `OP_JALR: begin
        dec.insn_class = `CLS_JALR;
        dec.use_imm    = 1'b1; // Target is rs1 + imm through the ALU
      end
      `OP_BRANCH: begin
        dec.insn_class = `CLS_BRANCH;
        dec.imm        = imm_b;
      end
      `OP_REG_IMM: begin
        dec.insn_class = `CLS_ALU;
        dec.use_imm    = 1'b1;
      end
      `OP_REG_REG: dec.insn_class = `CLS_ALU;
      `OP_ENVIRON: begin
        if (insn[31:7] == 25'd0)
          dec.insn_class = `CLS_HALT; // ECALL
      end
      `OP_MISC_MEM, `OP_LOAD, `OP_STORE: dec.insn_class = `CLS_NOP;
      default: dec.insn_class = `CLS_NOP;
    endcase
  end

  // ALU operation from funct3, funct7 picks sub and sra
  always_comb begin
    dec.alu_op = `ALU_ADD; // JALR and everything else adds
    if (opcode == `OP_REG_IMM || opcode == `OP_REG_REG) begin
      case (funct3)
        `F3_ADD_SUB:
          if (opcode == `OP_REG_REG && funct7 == `F7_ALT)
            dec.alu_op = `ALU_SUB;
        `F3_SLL:     dec.alu_op = `ALU_SLL;
        `F3_SLT:     dec.alu_op = `ALU_SLT;
        `F3_SLTU:    dec.alu_op = `ALU_SLTU;
        `F3_XOR:     dec.alu_op = `ALU_XOR;
        `F3_SRL_SRA: dec.alu_op = (funct7 == `F7_ALT) ? `ALU_SRA : `ALU_SRL;
        `F3_OR:      dec.alu_op = `ALU_OR;
        default:     dec.alu_op = `ALU_AND;
      endcase
    end
  end

  // No write for x0, branches, no-operations or ECALL
  assign dec.reg_write = (dec.rd != '0) &&
                         (dec.insn_class != `CLS_NOP) &&
                         (dec.insn_class != `CLS_BRANCH) &&
                         (dec.insn_class != `CLS_HALT);

endmodule

`default_nettype wire

/* source/rv_regfile.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_regfile (
  input  wire              clk,
  input  wire              rst,
  input  rv_pkg::reg_idx_t rs1,
  input  rv_pkg::reg_idx_t rs2,
  output rv_pkg::word_t    rs1_data,
  output rv_pkg::word_t    rs2_data,
  input  wire              we,
  input  rv_pkg::reg_idx_t rd,
  input  rv_pkg::word_t    wd
);
  import rv_pkg::*;

  word_t regs [1:31]; // x0 has no storage

  // rd is never x0 when we is high
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++)
        regs[i] <= '0;
    end else if (we) begin
      regs[rd] <= wd;
    end
  end

  // Asynchronous reads, x0 reads as zero
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

/* source/rv_execute.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rv_macros.svh"

module rv_execute (
  rv_decode_if.execute  dec,
  input  rv_pkg::word_t rs1_data,
  input  rv_pkg::word_t rs2_data,
  output rv_pkg::word_t alu_result,
  output logic          branch_taken
);
  import rv_pkg::*;

  word_t      op_b;
  logic [4:0] shamt;
  logic       eq;
  logic       lt_s;
  logic       lt_u;
  logic       cond;

  assign op_b  = dec.use_imm ? dec.imm : rs2_data;
  assign shamt = op_b[4:0];

  // Shared comparator, branches never select the immediate
  assign eq   = (rs1_data == op_b);
  assign lt_s = ($signed(rs1_data) < $signed(op_b));
  assign lt_u = (rs1_data < op_b);

  always_comb begin
    case (dec.alu_op)
      `ALU_SUB:  alu_result = rs1_data - op_b;
      `ALU_SLL:  alu_result = rs1_data << shamt;
      `ALU_SLT:  alu_result = {{(`XLEN-1){1'b0}}, lt_s};
      `ALU_SLTU: alu_result = {{(`XLEN-1){1'b0}}, lt_u};
      `ALU_XOR:  alu_result = rs1_data ^ op_b;
      `ALU_SRL:  alu_result = rs1_data >> shamt;
      `ALU_SRA:  alu_result = $signed(rs1_data) >>> shamt; // Sign fill
      `ALU_OR:   alu_result = rs1_data | op_b;
      `ALU_AND:  alu_result = rs1_data & op_b;
      default:   alu_result = rs1_data + op_b; // ADD
    endcase
  end

  always_comb begin
    case (dec.cmp_op)
      `F3_BEQ:  cond = eq;
      `F3_BNE:  cond = !eq;
      `F3_BLT:  cond = lt_s;
      `F3_BGE:  cond = !lt_s;
      `F3_BLTU: cond = lt_u;
      `F3_BGEU: cond = !lt_u;
      default:  cond = 1'b0; // Reserved encodings fall through
    endcase
  end

  assign branch_taken = cond && (dec.insn_class == `CLS_BRANCH);

endmodule

`default_nettype wire

/* source/rv_result.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rv_macros.svh"

module rv_result (
  input  wire              clk,
  input  wire              rst,
  rv_decode_if.result      dec,
  input  rv_pkg::word_t    alu_result,
  input  wire              branch_taken,
  output rv_pkg::word_t    pc,
  output logic             halt,
  output logic             wb_valid,
  output rv_pkg::reg_idx_t wb_rd,
  output rv_pkg::word_t    wb_data
);
  import rv_pkg::*;

  word_t pc_next;
  word_t pc_plus4;
  word_t pc_target; // Branch, JAL and AUIPC share this adder

  assign pc_plus4  = pc + 32'd4;
  assign pc_target = pc + dec.imm;

  always_comb begin
    if (branch_taken || dec.insn_class == `CLS_JAL)
      pc_next = pc_target;
    else if (dec.insn_class == `CLS_JALR)
      pc_next = {alu_result[`XLEN-1:1], 1'b0};
    else if (dec.insn_class == `CLS_HALT)
      pc_next = pc; // Stay on the ECALL
    else
      pc_next = pc_plus4;
  end

  always_ff @(posedge clk) begin
    if (rst)
      pc <= '0;
    else
      pc <= pc_next;
  end

  always_comb begin
    case (dec.insn_class)
      `CLS_LUI:            wb_data = dec.imm;
      `CLS_AUIPC:          wb_data = pc_target;
      `CLS_JAL, `CLS_JALR: wb_data = pc_plus4; // Link address
      default:             wb_data = alu_result;
    endcase
  end

  assign wb_rd    = dec.rd;
  assign wb_valid = dec.reg_write && !rst;
  assign halt     = (dec.insn_class == `CLS_HALT) && !rst;

endmodule

`default_nettype wire

/* source/rv_core.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_core (
  input  wire              clk,
  input  wire              rst,
  output rv_pkg::word_t    pc,
  input  rv_pkg::word_t    insn,
  output logic             halt,
  output logic             wb_valid,
  output rv_pkg::reg_idx_t wb_rd,
  output rv_pkg::word_t    wb_data
);
  import rv_pkg::*;

  word_t rs1_data;
  word_t rs2_data;
  word_t alu_result;
  logic  branch_taken;

  rv_decode_if dec_if ();

  rv_decode rv_decode_i (
    .insn (insn),
    .dec  (dec_if.decode)
  );

  // Write port fed by the commit trace
  rv_regfile rv_regfile_i (
    .clk      (clk),
    .rst      (rst),
    .rs1      (dec_if.rs1),
    .rs2      (dec_if.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .we       (wb_valid),
    .rd       (wb_rd),
    .wd       (wb_data)
  );

  rv_execute rv_execute_i (
    .dec          (dec_if.execute),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .alu_result   (alu_result),
    .branch_taken (branch_taken)
  );

  rv_result rv_result_i (
    .clk          (clk),
    .rst          (rst),
    .dec          (dec_if.result),
    .alu_result   (alu_result),
    .branch_taken (branch_taken),
    .pc           (pc),
    .halt         (halt),
    .wb_valid     (wb_valid),
    .wb_rd        (wb_rd),
    .wb_data      (wb_data)
  );

endmodule

`default_nettype wire

/* verif/rv_core_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_core_tb;
  import rv_pkg::*;

  localparam int MAX_ROWS   = 64;
  localparam int WAIT_LIMIT = 20; // Cycles allowed to reach a row's pc

  localparam logic [6:0] OPC_IMM    = 7'b0010011;
  localparam logic [6:0] OPC_REG    = 7'b0110011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam word_t NOP   = 32'h0000_0013; // addi x0, x0, 0
  localparam word_t FENCE = 32'h0FF0_000F;
  localparam word_t ECALL = 32'h0000_0073;
  localparam word_t UNDEF = 32'h0000_0FFF; // Opcode 7'h7f with rd x31

  logic     clk;
  logic     rst;
  word_t    pc;
  word_t    insn;
  logic     halt;
  logic     wb_valid;
  reg_idx_t wb_rd;
  word_t    wb_data;

  // Stimulus table with one row per retired instruction
  string    row_name  [MAX_ROWS];
  word_t    row_pc    [MAX_ROWS];
  word_t    row_insn  [MAX_ROWS];
  logic     row_valid [MAX_ROWS];
  reg_idx_t row_rd    [MAX_ROWS];
  word_t    row_data  [MAX_ROWS];
  logic     row_halt  [MAX_ROWS];
  int       row_count;
  word_t    build_pc; // Address of the next row while building
  int       mismatch_errors;
  int       timeout_errors;

  rv_core rv_core_i (
    .clk      (clk),
    .rst      (rst),
    .pc       (pc),
    .insn     (insn),
    .halt     (halt),
    .wb_valid (wb_valid),
    .wb_rd    (wb_rd),
    .wb_data  (wb_data)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic word_t enc_r(input logic [6:0] f7, input reg_idx_t rs2, rs1,
                                  input logic [2:0] f3, input reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, OPC_REG};
  endfunction

  function automatic word_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
                                  input logic [2:0] f3, input reg_idx_t rd,
                                  input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  // Byte offset with bit 0 implied
  function automatic word_t enc_b(input logic [12:0] off, input reg_idx_t rs2, rs1,
                                  input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
  endfunction

  function automatic word_t enc_j(input logic [20:0] off, input reg_idx_t rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
  endfunction

  function automatic word_t enc_u(input logic [19:0] imm, input reg_idx_t rd,
                                  input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  task automatic add_row(input string name, input word_t code, input logic valid,
                         input reg_idx_t rd, input word_t data, input logic halt_exp);
    row_name[row_count]  = name;
    row_pc[row_count]    = build_pc;
    row_insn[row_count]  = code;
    row_valid[row_count] = valid;
    row_rd[row_count]    = rd;
    row_data[row_count]  = data;
    row_halt[row_count]  = halt_exp;
    row_count++;
    build_pc = build_pc + 32'd4;
  endtask

  task automatic add_branch(input string name, input logic [2:0] f3, input reg_idx_t rs1,
                            input reg_idx_t rs2, input logic [12:0] off, input logic taken);
    word_t here;
    here = build_pc;
    add_row(name, enc_b(off, rs2, rs1, f3), 1'b0, 5'd0, 32'd0, 1'b0);
    if (taken)
      build_pc = here + {{19{off[12]}}, off};
  endtask

  // x1 = -100 and x2 = 1234 drive most expected values below
  task automatic build_program();
    word_t halt_pc;
    add_row("first_step", NOP, 1'b0, 5'd0, 32'd0, 1'b0);
    add_row("early_read", enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd5), 1'b1, 5'd5, 32'd0, 1'b0);
    add_row("addi_neg", enc_i(12'hF9C, 5'd0, 3'd0, 5'd1, OPC_IMM), 1'b1, 5'd1, 32'hFFFF_FF9C, 1'b0);
    add_row("addi_pos", enc_i(12'h4D2, 5'd0, 3'd0, 5'd2, OPC_IMM), 1'b1, 5'd2, 32'h0000_04D2, 1'b0);
    add_row("slti", enc_i(12'h005, 5'd1, 3'd2, 5'd3, OPC_IMM), 1'b1, 5'd3, 32'd1, 1'b0);
    add_row("sltiu", enc_i(12'h005, 5'd1, 3'd3, 5'd4, OPC_IMM), 1'b1, 5'd4, 32'd0, 1'b0);
    add_row("xori", enc_i(12'h0FF, 5'd2, 3'd4, 5'd6, OPC_IMM), 1'b1, 5'd6, 32'h0000_042D, 1'b0);
    add_row("ori", enc_i(12'h0F0, 5'd1, 3'd6, 5'd7, OPC_IMM), 1'b1, 5'd7, 32'hFFFF_FFFC, 1'b0);
    add_row("andi", enc_i(12'h0F0, 5'd2, 3'd7, 5'd8, OPC_IMM), 1'b1, 5'd8, 32'h0000_00D0, 1'b0);
    add_row("slli", enc_i(12'h008, 5'd2, 3'd1, 5'd9, OPC_IMM), 1'b1, 5'd9, 32'h0004_D200, 1'b0);
    add_row("srli", enc_i(12'h004, 5'd1, 3'd5, 5'd10, OPC_IMM), 1'b1, 5'd10, 32'h0FFF_FFF9, 1'b0);
    add_row("srai", enc_i(12'h404, 5'd1, 3'd5, 5'd11, OPC_IMM), 1'b1, 5'd11, 32'hFFFF_FFF9, 1'b0);
    // Shift amount 13 comes from x6
    add_row("add", enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd12), 1'b1, 5'd12, 32'h0000_046E, 1'b0);
    add_row("sub", enc_r(7'h20, 5'd2, 5'd1, 3'd0, 5'd13), 1'b1, 5'd13, 32'hFFFF_FACA, 1'b0);
    add_row("sll", enc_r(7'h00, 5'd6, 5'd2, 3'd1, 5'd14), 1'b1, 5'd14, 32'h009A_4000, 1'b0);
    add_row("slt", enc_r(7'h00, 5'd2, 5'd1, 3'd2, 5'd15), 1'b1, 5'd15, 32'd1, 1'b0);
    add_row("sltu", enc_r(7'h00, 5'd2, 5'd1, 3'd3, 5'd16), 1'b1, 5'd16, 32'd0, 1'b0);
    add_row("xor", enc_r(7'h00, 5'd2, 5'd1, 3'd4, 5'd17), 1'b1, 5'd17, 32'hFFFF_FB4E, 1'b0);
    add_row("srl", enc_r(7'h00, 5'd6, 5'd1, 3'd5, 5'd18), 1'b1, 5'd18, 32'h0007_FFFF, 1'b0);
    add_row("sra", enc_r(7'h20, 5'd6, 5'd1, 3'd5, 5'd19), 1'b1, 5'd19, 32'hFFFF_FFFF, 1'b0);
    add_row("or", enc_r(7'h00, 5'd2, 5'd1, 3'd6, 5'd20), 1'b1, 5'd20, 32'hFFFF_FFDE, 1'b0);
    add_row("and", enc_r(7'h00, 5'd2, 5'd1, 3'd7, 5'd21), 1'b1, 5'd21, 32'h0000_0490, 1'b0);
    add_row("lui", enc_u(20'h12345, 5'd22, OPC_LUI), 1'b1, 5'd22, 32'h1234_5000, 1'b0);
    add_row("auipc", enc_u(20'h00001, 5'd23, OPC_AUIPC), 1'b1, 5'd23, 32'h0000_105C, 1'b0);
    add_row("addi_x0", enc_i(12'h007, 5'd1, 3'd0, 5'd0, OPC_IMM), 1'b0, 5'd0, 32'd0, 1'b0);
    add_row("read_x0", enc_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd24), 1'b1, 5'd24, 32'd0, 1'b0);
    add_branch("beq_not", 3'd0, 5'd1, 5'd2, 13'd8, 1'b0);
    add_branch("beq_taken", 3'd0, 5'd2, 5'd2, 13'd12, 1'b1);
    add_branch("bne_not", 3'd1, 5'd2, 5'd2, 13'd8, 1'b0);
    add_branch("bne_taken", 3'd1, 5'd1, 5'd2, 13'd16, 1'b1);
    add_branch("blt_not", 3'd4, 5'd2, 5'd1, 13'd8, 1'b0);
    add_branch("blt_taken", 3'd4, 5'd1, 5'd2, 13'd8, 1'b1);
    add_branch("bge_not", 3'd5, 5'd1, 5'd2, 13'd8, 1'b0);
    add_branch("bge_back", 3'd5, 5'd2, 5'd1, 13'h1FF8, 1'b1); // Backward to 148
    add_branch("bltu_taken", 3'd6, 5'd2, 5'd1, 13'd12, 1'b1);
    add_branch("bltu_not", 3'd6, 5'd1, 5'd2, 13'd8, 1'b0);
    add_branch("bgeu_not", 3'd7, 5'd2, 5'd1, 13'd8, 1'b0);
    add_branch("bgeu_taken", 3'd7, 5'd1, 5'd2, 13'd8, 1'b1);
    add_row("jal", enc_j(21'd24, 5'd25), 1'b1, 5'd25, 32'd180, 1'b0);
    build_pc = 32'd200;
    // x12 is 1134 so the target 241 drops bit 0
    add_row("jalr", enc_i(12'hC83, 5'd12, 3'd0, 5'd26, OPC_JALR), 1'b1, 5'd26, 32'd204, 1'b0);
    build_pc = 32'd240;
    add_row("fence", FENCE, 1'b0, 5'd0, 32'd0, 1'b0);
    add_row("undefined", UNDEF, 1'b0, 5'd0, 32'd0, 1'b0);
    halt_pc = build_pc;
    for (int k = 0; k < 4; k++) begin
      if (k == 0)
        add_row("ecall", ECALL, 1'b0, 5'd0, 32'd0, 1'b1);
      else
        add_row("halt_hold", ECALL, 1'b0, 5'd0, 32'd0, 1'b1);
      build_pc = halt_pc;
    end
  endtask

  task automatic check_word(input string name, input string what, input word_t expected,
                            input word_t actual);
    if (actual !== expected) begin
      $display("Mismatch %s: %s expected %h, actual %h", name, what, expected, actual);
      mismatch_errors++;
    end
  endtask

  task automatic check_idx(input string name, input string what, input reg_idx_t expected,
                           input reg_idx_t actual);
    if (actual !== expected) begin
      $display("Mismatch %s: %s expected x%0d, actual x%0d", name, what, expected, actual);
      mismatch_errors++;
    end
  endtask

  task automatic check_bit(input string name, input string what, input logic expected,
                           input logic actual);
    if (actual !== expected) begin
      $display("Mismatch %s: %s expected %b, actual %b", name, what, expected, actual);
      mismatch_errors++;
    end
  endtask

  // Feeds no-operations until pc arrives
  task automatic wait_for_pc(input word_t target, output logic reached);
    int cycles;
    cycles = 0;
    while (pc !== target && cycles < WAIT_LIMIT) begin
      insn = NOP;
      @(posedge clk);
      #2;
      cycles++;
    end
    reached = (pc === target);
  endtask

  initial begin
    logic reached;
    rst             = 1'b1;
    insn            = NOP;
    mismatch_errors = 0;
    timeout_errors  = 0;
    row_count       = 0;
    build_pc        = '0;
    build_program();

    // Writes and ECALL presented under reset must stay silent
    for (int i = 0; i < 7; i++) begin
      @(posedge clk);
      #2;
      insn = (i < 4) ? enc_i(12'h005, 5'd0, 3'd0, 5'd1, OPC_IMM) : ECALL;
      #10;
      check_word("reset", "pc", 32'd0, pc);
      check_bit("reset", "wb_valid", 1'b0, wb_valid);
      check_bit("reset", "halt", 1'b0, halt);
    end
    @(posedge clk);
    #2;
    rst = 1'b0;

    reached = 1'b1;
    for (int i = 0; i < row_count && reached; i++) begin
      // No stalls exist, so pc must already match the row
      check_word(row_name[i], "pc", row_pc[i], pc);
      wait_for_pc(row_pc[i], reached);
      if (!reached) begin
        $display("Timeout in %s: pc never reached %h within %0d cycles",
                 row_name[i], row_pc[i], WAIT_LIMIT);
        timeout_errors++;
      end else begin
        insn = row_insn[i];
        #10;
        check_bit(row_name[i], "wb_valid", row_valid[i], wb_valid);
        check_bit(row_name[i], "halt", row_halt[i], halt);
        if (row_valid[i]) begin
          check_idx(row_name[i], "wb_rd", row_rd[i], wb_rd);
          check_word(row_name[i], "wb_data", row_data[i], wb_data);
        end
        @(posedge clk);
        #2;
      end
    end

    $display("Errors: %0d mismatches, %0d timeouts", mismatch_errors, timeout_errors);
    if (mismatch_errors == 0 && timeout_errors == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* rv_core.f */
+incdir+source
source/rv_pkg.sv
source/rv_decode_if.sv
source/rv_decode.sv
source/rv_regfile.sv
source/rv_execute.sv
source/rv_result.sv
source/rv_core.sv
verif/rv_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run rv_core_tb with Verilator, then scan the log for the verdict

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -f rv_core.f --top-module rv_core_tb -o rv_core_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/rv_core_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TEST RESULT: FAIL" "$LOG"; then
  exit 1
fi
if ! grep -q "TEST RESULT: PASS" "$LOG"; then
  echo "No verdict found in $LOG"
  exit 1
fi
exit 0
